//--- fpCvtPkg.sv
// shared constants and types for the double <-> 64-bit integer converter
// only IEEE 754 binary64 is supported, the widths below are fixed
// rounding everywhere is half up on the magnitude (ties away from zero)
// denormals are treated as zero, no flags besides overflow exist

package fpCvtPkg;

	// ===================================================================
	// format widths
	// ===================================================================

	localparam int fpWidth  = 64;            // total word width
	localparam int expWidth = 11;            // biased exponent field
	localparam int manWidth = 52;            // stored fraction, hidden bit not stored
	localparam int sigWidth = manWidth + 1;  // significand incl. hidden bit
	localparam int expBias  = 1023;          // exponent bias of binary64

	// saturation limits for the two integer modes
	localparam logic [fpWidth-1:0] sIntMax = {1'b0, {(fpWidth-1){1'b1}}};  // 2^63-1
	localparam logic [fpWidth-1:0] uIntMax = {fpWidth{1'b1}};              // 2^64-1

	// ===================================================================
	// word views
	// ===================================================================

	// binary64 split into its fields, msb first
	typedef struct packed {
		logic                sign;  // 1 = negative
		logic [expWidth-1:0] exp;   // biased exponent, all ones = inf/NaN
		logic [manWidth-1:0] man;   // fraction bits
	} fp64T;

	// one 64-bit word, read either as a double or as an integer
	// the integer view is two's complement or unsigned depending on mode
	typedef union packed {
		fp64T               fp;      // floating-point view
		logic [fpWidth-1:0] intVal;  // integer view
	} cvtWordT;

	// ===================================================================
	// operation select
	// ===================================================================

	typedef enum logic [0:0] {
		cvtF2I = 1'b0,  // double to integer
		cvtI2F = 1'b1   // integer to double
	} cvtFuncT;

endpackage

//--- fpToInt.sv
// double to 64-bit integer in signed or unsigned mode with one registered stage
// rounding is half up on the magnitude and below one half gives zero
// too large values, inf and NaN saturate to the mode maximum with overflow
// signed saturation is +/-(2^63-1) so -2^63 is never produced
// unsigned mode ignores the sign and converts the magnitude
// the final negate sits after the register and nothing is clocked without ce

module fpToInt (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          ce,
	input  logic                          isSigned,  // 1 = two's complement result
	input  fpCvtPkg::fp64T                operand,
	output logic [fpCvtPkg::fpWidth-1:0]  intOut,
	output logic                          overflow
);

	// ===================================================================
	// decode and classify
	// ===================================================================

	logic [fpCvtPkg::sigWidth-1:0] sig;      // significand with hidden bit
	logic [fpCvtPkg::fpWidth-1:0]  maxInt;   // saturation value for this mode
	logic                          isUnder;  // below one half including zero and denormals
	logic                          isHalf;   // magnitude in [0.5, 1)
	logic                          isOvf;    // does not fit or is inf/NaN

	assign sig     = {operand.exp != '0, operand.man};  // hidden bit only for normals
	assign maxInt  = isSigned ? fpCvtPkg::sIntMax : fpCvtPkg::uIntMax;
	assign isUnder = operand.exp < fpCvtPkg::expWidth'(fpCvtPkg::expBias - 1);
	assign isHalf  = operand.exp == fpCvtPkg::expWidth'(fpCvtPkg::expBias - 1);

	// largest unbiased exponent that still fits is 62 signed and 63 unsigned
	// exp all ones is far above either limit so inf/NaN fall in here as well
	always_comb begin
		if (isSigned)
			isOvf = operand.exp > fpCvtPkg::expWidth'(fpCvtPkg::expBias + fpCvtPkg::fpWidth - 2);
		else
			isOvf = operand.exp > fpCvtPkg::expWidth'(fpCvtPkg::expBias + fpCvtPkg::fpWidth - 1);
	end

	// ===================================================================
	// align and round
	// ===================================================================

	// the hidden bit starts at bit 64 of a 65-bit frame and moves down
	// to bit (e + 1), so bits [64:1] hold the integer part and bit 0 is
	// the first dropped bit (weight one half)
	logic [5:0]                    shamt;    // 63 - unbiased exponent
	logic [fpCvtPkg::fpWidth:0]    shifted;  // integer part plus round bit
	logic [fpCvtPkg::fpWidth-1:0]  rounded;  // half up applied

	// only meaningful for exponents 0..63 since other cases are caught above
	assign shamt   = 6'(fpCvtPkg::expBias + fpCvtPkg::fpWidth - 1 - int'(operand.exp));
	assign shifted = {sig, {(fpCvtPkg::fpWidth + 1 - fpCvtPkg::sigWidth){1'b0}}} >> shamt;
	assign rounded = shifted[fpCvtPkg::fpWidth:1] + shifted[0];  // e >= 52 is exact so no carry

	// ===================================================================
	// result register
	// ===================================================================

	logic [fpCvtPkg::fpWidth-1:0] magQ;     // unsigned magnitude
	logic                         sgnQ;     // operand sign
	logic                         signedQ;  // mode of this result
	logic                         ovfQ;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			magQ    <= '0;
			sgnQ    <= 1'b0;
			signedQ <= 1'b0;
			ovfQ    <= 1'b0;
		end else if (ce) begin
			sgnQ    <= operand.sign;
			signedQ <= isSigned;
			ovfQ    <= isOvf;
			if (isUnder)
				magQ <= '0;          // below one half
			else if (isOvf)
				magQ <= maxInt;      // saturate
			else if (isHalf)
				magQ <= 64'd1;       // [0.5, 1) rounds up to one
			else
				magQ <= rounded;
		end
	end

	// negate after the register while unsigned mode keeps the magnitude
	assign intOut   = (signedQ && sgnQ) ? -magQ : magQ;
	assign overflow = ovfQ;

	// ===================================================================
	// checks
	// ===================================================================

	// a flagged result must carry the saturation value of its own mode
	assert property (@(posedge clk) disable iff (!arstN)
		ovfQ |-> (magQ == (signedQ ? fpCvtPkg::sIntMax : fpCvtPkg::uIntMax)));

	// a zero accepted on ce never comes back flagged
	assert property (@(posedge clk) disable iff (!arstN)
		(ce && operand.exp == '0 && operand.man == '0) |=> !overflow);

endmodule

//--- intToFp.sv
// 64-bit integer to double, signed or unsigned, one registered stage
// all normalization and rounding happen before the register
// rounding is half up on the first dropped bit, ties go away from zero
// zero input gives +0, the exponent cannot reach inf so there is no overflow
// the most negative signed value converts exactly to -2^63

module intToFp (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          ce,
	input  logic                          isSigned,  // 1 = intIn is two's complement
	input  logic [fpCvtPkg::fpWidth-1:0]  intIn,
	output fpCvtPkg::fp64T                fpOut
);

	// ===================================================================
	// sign and magnitude
	// ===================================================================

	logic                         neg;     // negative signed input
	logic [fpCvtPkg::fpWidth-1:0] absVal;  // magnitude, 2^63 fits unsigned
	logic                         isZero;

	assign neg    = isSigned && intIn[fpCvtPkg::fpWidth-1];
	assign absVal = neg ? -intIn : intIn;
	assign isZero = absVal == '0;

	// ===================================================================
	// leading zero count
	// ===================================================================

	// priority search, the highest set bit wins since it is visited last
	// result is don't care for a zero input, handled separately
	logic [5:0] lzc;

	always_comb begin
		lzc = 6'd0;
		for (int i = 0; i < fpCvtPkg::fpWidth; i++) begin
			if (absVal[i])
				lzc = 6'(fpCvtPkg::fpWidth - 1 - i);
		end
	end

	// ===================================================================
	// normalize and round
	// ===================================================================

	logic [fpCvtPkg::fpWidth-1:0]  norm;     // top set bit moved to bit 63
	logic [fpCvtPkg::manWidth:0]   fracRnd;  // fraction plus carry bit
	logic                          roundBit; // first bit below the fraction
	logic                          carry;    // rounding wrapped the fraction
	logic [fpCvtPkg::expWidth-1:0] expNext;  // biased exponent

	assign norm = absVal << lzc;

	// bit 63 becomes the hidden bit, next 52 bits are the fraction
	assign roundBit = norm[fpCvtPkg::fpWidth - fpCvtPkg::sigWidth - 1];
	assign fracRnd  = {1'b0, norm[fpCvtPkg::fpWidth-2 -: fpCvtPkg::manWidth]}
		+ (fpCvtPkg::manWidth + 1)'(roundBit);
	assign carry    = fracRnd[fpCvtPkg::manWidth];

	// value is 1.f * 2^(63 - lzc), one more if the fraction wrapped
	// on a wrap the fraction bits are already all zero
	// largest case is 1023 + 64, well below all ones
	assign expNext = fpCvtPkg::expWidth'(fpCvtPkg::expBias + fpCvtPkg::fpWidth - 1
		- int'(lzc) + int'(carry));

	// ===================================================================
	// result register
	// ===================================================================

	fpCvtPkg::fp64T fpQ;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			fpQ <= '0;
		end else if (ce) begin
			if (isZero) begin
				fpQ <= '0;  // +0
			end else begin
				fpQ.sign <= neg;
				fpQ.exp  <= expNext;
				fpQ.man  <= fracRnd[fpCvtPkg::manWidth-1:0];
			end
		end
	end

	assign fpOut = fpQ;

	// ===================================================================
	// checks
	// ===================================================================

	// 64-bit inputs can never produce inf or NaN
	assert property (@(posedge clk) disable iff (!arstN)
		fpQ.exp != '1);

endmodule

//--- fpCvtUnit.sv
// conversion unit between binary64 and 64-bit integers
// both converters run in parallel on every enabled cycle
// func is registered with the operand and picks the result one cycle later
// there is no handshake and ce low freezes all state and holds the result
// overflow is only reported for double to integer

module fpCvtUnit (
	input  logic              clk,
	input  logic              arstN,
	input  logic              ce,        // capture operand on this edge
	input  fpCvtPkg::cvtFuncT func,      // direction of this operation
	input  logic              isSigned,  // integer side is two's complement
	input  fpCvtPkg::cvtWordT operand,
	output fpCvtPkg::cvtWordT result,
	output logic              overflow
);

	// ===================================================================
	// function select register
	// ===================================================================

	fpCvtPkg::cvtFuncT funcQ;  // direction of the value now in the converters

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			funcQ <= fpCvtPkg::cvtF2I;
		else if (ce)
			funcQ <= func;
	end

	// ===================================================================
	// converters
	// ===================================================================

	logic [fpCvtPkg::fpWidth-1:0] f2iRes;  // integer result
	logic                         f2iOvf;  // saturation flag
	fpCvtPkg::fp64T               i2fRes;  // double result

	// same word goes to both and each reads its own view
	fpToInt uFpToInt (
		.clk      (clk),
		.arstN    (arstN),
		.ce       (ce),
		.isSigned (isSigned),
		.operand  (operand.fp),
		.intOut   (f2iRes),
		.overflow (f2iOvf)
	);

	intToFp uIntToFp (
		.clk      (clk),
		.arstN    (arstN),
		.ce       (ce),
		.isSigned (isSigned),
		.intIn    (operand.intVal),
		.fpOut    (i2fRes)
	);

	// ===================================================================
	// result select
	// ===================================================================

	always_comb begin
		if (funcQ == fpCvtPkg::cvtI2F)
			result.fp = i2fRes;
		else
			result.intVal = f2iRes;
	end

	// integer to double never saturates
	assign overflow = f2iOvf && (funcQ == fpCvtPkg::cvtF2I);

	// an integer to double operation accepted on ce comes back without the flag
	assert property (@(posedge clk) disable iff (!arstN)
		(ce && func == fpCvtPkg::cvtI2F) |=> !overflow);

endmodule

//--- tbFpCvt.sv
// directed testbench for the double <-> 64-bit integer conversion unit
// expected values come from two bit-level models of the rounding rules
// (half up on the magnitude, below one half is zero, saturation by mode)
// inputs change on the rising edge, outputs are sampled on the falling edge
// the first mismatch stops the run, a cycle counter guards against hangs

module tbFpCvt;

	timeunit 1ns;
	timeprecision 1ps;

	// ===================================================================
	// clock, reset, DUT
	// ===================================================================

	localparam int timeoutCycles = 2000;  // about twice the ~950 cycles the tests need

	// expected integer result, value plus saturation flag
	typedef struct packed {
		logic                         ovf;
		logic [fpCvtPkg::fpWidth-1:0] val;
	} expIntT;

	logic              clk = 1'b0;
	logic              arstN;
	logic              ce;
	fpCvtPkg::cvtFuncT func;
	logic              isSigned;
	fpCvtPkg::cvtWordT operand;
	fpCvtPkg::cvtWordT result;
	logic              overflow;
	int                cycleCount = 0;

	always #4 clk = ~clk;  // 8 ns period

	fpCvtUnit DUT (
		.clk      (clk),
		.arstN    (arstN),
		.ce       (ce),
		.func     (func),
		.isSigned (isSigned),
		.operand  (operand),
		.result   (result),
		.overflow (overflow)
	);

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("the run timed out after %0d cycles", cycleCount);
			stopRun();
		end
	end

	// ===================================================================
	// reference models
	// ===================================================================

	// double to integer straight from exponent and fraction
	function automatic expIntT modelF2I(fpCvtPkg::fp64T d, logic sgnMode);
		expIntT      r;
		int          e;
		int          sh;
		logic [52:0] sig;
		logic [63:0] mag;
		logic [63:0] maxVal;
		maxVal = sgnMode ? 64'h7fff_ffff_ffff_ffff : 64'hffff_ffff_ffff_ffff;
		sig    = {1'b1, d.man};
		e      = int'(d.exp) - 1023;  // unbiased
		r.ovf  = 1'b0;
		if (d.exp == 11'd0) begin
			mag = '0;                   // zero and denormals
		end else if (d.exp == 11'h7ff || e > (sgnMode ? 62 : 63)) begin
			r.ovf = 1'b1;               // inf, NaN, out of range
			mag   = maxVal;
		end else if (e < -1) begin
			mag = '0;                   // below one half
		end else if (e == -1) begin
			mag = 64'd1;                // [0.5, 1)
		end else if (e >= 52) begin
			mag = 64'(sig) << (e - 52); // exact, no fraction left
		end else begin
			sh  = 52 - e;
			mag = 64'(sig >> sh) + 64'(sig[sh-1]);  // add the half bit
		end
		r.val = (sgnMode && d.sign) ? -mag : mag;
		return r;
	endfunction

	// integer to double, leading one search then half up
	function automatic fpCvtPkg::fp64T modelI2F(logic [63:0] x, logic sgnMode);
		fpCvtPkg::fp64T r;
		logic           neg;
		logic [63:0]    mag;
		logic [64:0]    m;
		int             p;
		int             drop;
		neg = sgnMode && x[63];
		mag = neg ? -x : x;
		r   = '0;
		if (mag == '0)
			return r;                  // +0
		p = 0;
		for (int i = 0; i < 64; i++) begin
			if (mag[i])
				p = i;                   // position of the leading one
		end
		if (p <= 52) begin
			m = 65'(mag) << (52 - p);
		end else begin
			drop = p - 52;
			m    = 65'(mag >> drop) + 65'(mag[drop-1]);
		end
		if (m[53]) begin             // rounding reached the next power of two
			m = m >> 1;
			p++;
		end
		r.sign = neg;
		r.exp  = 11'(1023 + p);
		r.man  = m[51:0];
		return r;
	endfunction

	// ===================================================================
	// checks
	// ===================================================================

	task automatic stopRun();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic reportValue(string name, logic [63:0] got, logic [63:0] exp);
		$display("ERROR %s got %h expected %h", name, got, exp);
		stopRun();
	endtask

	task automatic checkInt(fpCvtPkg::cvtWordT got, logic gotOvf, expIntT exp);
		if (got.intVal !== exp.val)
			reportValue("result", got.intVal, exp.val);
		if (gotOvf !== exp.ovf)
			reportValue("overflow", 64'(gotOvf), 64'(exp.ovf));
	endtask

	// double results never carry an overflow
	task automatic checkFp(fpCvtPkg::fp64T got, logic gotOvf, fpCvtPkg::fp64T exp);
		if (got !== exp)
			reportValue("result", got, exp);
		if (gotOvf !== 1'b0)
			reportValue("overflow", 64'(gotOvf), 64'd0);
	endtask

	// compare current outputs with the model for one operation
	task automatic checkOp(fpCvtPkg::cvtFuncT f, logic s, logic [63:0] w);
		fpCvtPkg::cvtWordT wv;
		wv.intVal = w;
		if (f == fpCvtPkg::cvtF2I)
			checkInt(result, overflow, modelF2I(wv.fp, s));
		else
			checkFp(result.fp, overflow, modelI2F(w, s));
	endtask

	// ===================================================================
	// drivers
	// ===================================================================

	// call right after a rising edge
	task automatic driveOp(fpCvtPkg::cvtFuncT f, logic s, logic [63:0] w);
		func           <= f;
		isSigned       <= s;
		operand.intVal <= w;
		ce             <= 1'b1;
	endtask

	// single operation, result is checked one edge after capture
	task automatic runOp(fpCvtPkg::cvtFuncT f, logic s, logic [63:0] w);
		@(posedge clk);
		driveOp(f, s, w);
		@(posedge clk);  // capture edge
		ce <= 1'b0;
		@(negedge clk);
		checkOp(f, s, w);
	endtask

	task automatic testF2I(logic [63:0] bits);
		runOp(fpCvtPkg::cvtF2I, 1'b1, bits);
		runOp(fpCvtPkg::cvtF2I, 1'b0, bits);
	endtask

	task automatic testI2F(logic [63:0] bits);
		runOp(fpCvtPkg::cvtI2F, 1'b1, bits);
		runOp(fpCvtPkg::cvtI2F, 1'b0, bits);
	endtask

	// ===================================================================
	// tests
	// ===================================================================

	task automatic testReset();
		expIntT zero;
		zero = '0;
		@(negedge clk);
		checkInt(result, overflow, zero);
	endtask

	task automatic testF2IRounding();
		testF2I($realtobits(1.0));
		testF2I($realtobits(2.5));           // tie goes up
		testF2I($realtobits(1.0e6));
		testF2I($realtobits(0.4));           // below one half
		testF2I($realtobits(0.5));
		testF2I($realtobits(0.75));
		testF2I($realtobits(-3.5));          // magnitude only when unsigned
		testF2I($realtobits(-0.5));
		testF2I($realtobits(2251799813685248.5));
		testF2I(64'h8000_0000_0000_0000);    // -0
		testF2I(64'h0000_0000_0000_0001);    // smallest denormal
		testF2I(64'h43df_ffff_ffff_ffff);    // largest below 2^63
	endtask

	task automatic testF2ISaturation();
		testF2I(64'h43e0_0000_0000_0000);    // 2^63, fits unsigned only
		testF2I(64'h43f0_0000_0000_0000);    // 2^64
		testF2I(64'h7ff0_0000_0000_0000);    // +inf
		testF2I(64'hfff0_0000_0000_0000);    // -inf
		testF2I(64'h7ff8_0000_0000_0000);    // quiet NaN
		testF2I($realtobits(-1.0e30));
		// same words read as integers, flag must stay low
		runOp(fpCvtPkg::cvtI2F, 1'b1, 64'h7ff0_0000_0000_0000);
		runOp(fpCvtPkg::cvtI2F, 1'b0, $realtobits(-1.0e30));
	endtask

	task automatic testI2FDirected();
		testI2F(64'd0);
		testI2F(64'd1);
		testI2F(64'hffff_ffff_ffff_ffff);    // -1 or 2^64-1
		testI2F(64'h0020_0000_0000_0001);    // 2^53+1, tie
		testI2F(64'h0020_0000_0000_0003);    // 2^53+3, tie
		testI2F(64'hffdf_ffff_ffff_ffff);    // -(2^53+1) when signed
		testI2F(64'h0040_0000_0000_0002);    // 2^54+2, tie two units down
		testI2F(64'h8000_0000_0000_0000);    // most negative signed
		testI2F(64'h7fff_ffff_ffff_ffff);
	endtask

	task automatic testI2FRandom();
		logic [63:0] w;
		for (int i = 0; i < 200; i++) begin
			w = {$urandom, $urandom} >> ($urandom % 64);  // spread the magnitudes
			if ($urandom % 2)
				w = -w;
			testI2F(w);
		end
	endtask

	// alternate directions with ce held high
	task automatic testBackToBack();
		fpCvtPkg::cvtFuncT fq[12];
		logic              sq[12];
		logic [63:0]       wq[12];
		real               vals[6] = '{7.5, -2.5, 1.0e18, 0.5, 1.0e30, -123.5};
		for (int i = 0; i < 12; i++) begin
			fq[i] = (i % 2) ? fpCvtPkg::cvtI2F : fpCvtPkg::cvtF2I;
			sq[i] = (i % 4) < 2;
			wq[i] = (i % 2) ? {$urandom, $urandom} : $realtobits(vals[i / 2]);
		end
		@(posedge clk);
		driveOp(fq[0], sq[0], wq[0]);
		for (int i = 0; i < 12; i++) begin
			@(posedge clk);
			if (i < 11)
				driveOp(fq[i+1], sq[i+1], wq[i+1]);
			else
				ce <= 1'b0;
			@(negedge clk);
			checkOp(fq[i], sq[i], wq[i]);
		end
	endtask

	// result must stay frozen while ce is low and the inputs move
	task automatic holdCheck(fpCvtPkg::cvtFuncT f, logic s, logic [63:0] w);
		runOp(f, s, w);
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			ce             <= 1'b0;
			func           <= (i % 2) ? fpCvtPkg::cvtI2F : fpCvtPkg::cvtF2I;
			isSigned       <= ~s;
			operand.intVal <= {$urandom, $urandom};
			@(negedge clk);
			checkOp(f, s, w);
		end
	endtask

	task automatic testCeHold();
		holdCheck(fpCvtPkg::cvtF2I, 1'b1, $realtobits(-1.0e30));  // flag held high
		holdCheck(fpCvtPkg::cvtI2F, 1'b1, 64'hffdf_ffff_ffff_ffff);
	endtask

	// ===================================================================
	// main sequence
	// ===================================================================

	initial begin
		void'($urandom(32'hfe65df22));
		arstN          = 1'b0;
		ce             = 1'b0;
		func           = fpCvtPkg::cvtF2I;
		isSigned       = 1'b0;
		operand.intVal = '0;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;

		testReset();
		testF2IRounding();
		testF2ISaturation();
		testI2FDirected();
		testI2FRandom();
		testBackToBack();
		testCeHold();

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- all.f
fpCvtPkg.sv
fpToInt.sv
intToFp.sv
fpCvtUnit.sv
tbFpCvt.sv

//--- Bender.yml
package:
  name: fpCvt

sources:
  - fpCvtPkg.sv
  - fpToInt.sv
  - intToFp.sv
  - fpCvtUnit.sv
  - target: test
    files:
      - tbFpCvt.sv
